/* list.f */
+incdir+testbench
verilog/desKeyPkg.sv
verilog/keyIntake.sv
verilog/keyPermChoice1.sv
verilog/keyPermChoice2.sv
verilog/roundKeyEngine.sv
verilog/subkeyOutput.sv
verilog/desKeySchedule.sv
testbench/tbDesKeySchedule.sv

/* testbench/tbDesRefModel.svh */
`ifndef TB_DES_REF_MODEL_SVH
`define TB_DES_REF_MODEL_SVH

// FIPS 46-3 tables with one byte per entry and the first entry in the top byte.
localparam logic [447:0] PC1_TAB = {
   8'd57, 8'd49, 8'd41, 8'd33, 8'd25, 8'd17, 8'd9, 8'd1, 8'd58, 8'd50, 8'd42, 8'd34,
   8'd26, 8'd18, 8'd10, 8'd2, 8'd59, 8'd51, 8'd43, 8'd35, 8'd27, 8'd19, 8'd11, 8'd3,
   8'd60, 8'd52, 8'd44, 8'd36, 8'd63, 8'd55, 8'd47, 8'd39, 8'd31, 8'd23, 8'd15, 8'd7,
   8'd62, 8'd54, 8'd46, 8'd38, 8'd30, 8'd22, 8'd14, 8'd6, 8'd61, 8'd53, 8'd45, 8'd37,
   8'd29, 8'd21, 8'd13, 8'd5, 8'd28, 8'd20, 8'd12, 8'd4
};
localparam logic [383:0] PC2_TAB = {
   8'd14, 8'd17, 8'd11, 8'd24, 8'd1, 8'd5, 8'd3, 8'd28, 8'd15, 8'd6, 8'd21, 8'd10,
   8'd23, 8'd19, 8'd12, 8'd4, 8'd26, 8'd8, 8'd16, 8'd7, 8'd27, 8'd20, 8'd13, 8'd2,
   8'd41, 8'd52, 8'd31, 8'd37, 8'd47, 8'd55, 8'd30, 8'd40, 8'd51, 8'd45, 8'd33, 8'd48,
   8'd44, 8'd49, 8'd39, 8'd56, 8'd34, 8'd53, 8'd46, 8'd42, 8'd50, 8'd36, 8'd29, 8'd32
};

// each key byte keeps its upper seven bits and loses the parity bit.
function automatic logic [55:0] stripParity(input logic [63:0] k64);
   logic [55:0] k56;
   for (int b = 0; b < 8; b++) begin
      k56[7*b +: 7] = k64[8*b+1 +: 7];
   end
   return k56;
endfunction

// table entry p names source bit p counted from the MSB.
// the result is right aligned in n bits.
function automatic logic [55:0] pickBits(input logic [63:0] src, input int width,
                                         input logic [447:0] tab, input int n);
   logic [55:0] dst;
   dst = '0;
   for (int i = 0; i < n; i++) begin
      dst[n-1-i] = src[width - tab[8*(n-1-i) +: 8]];
   end
   return dst;
endfunction

function automatic logic [27:0] rotl28(input logic [27:0] h, input int n);
   return (h << n) | (h >> (28 - n));
endfunction

// the subkey of round r+1 sits at bits [48*r +: 48].
function automatic logic [767:0] refSchedule(input logic [63:0] k64);
   logic [55:0]  cd;
   logic [55:0]  sk;
   logic [767:0] ks;
   int           n;
   cd = pickBits(k64, 64, PC1_TAB, 56);
   for (int r = 0; r < 16; r++) begin
      n  = SHIFT_ONE[r] ? 1 : 2;
      cd = {rotl28(cd[55:28], n), rotl28(cd[27:0], n)};
      sk = pickBits({8'h00, cd}, 56, {64'h0, PC2_TAB}, 48);
      ks[48*r +: 48] = sk[47:0];
   end
   return ks;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
   s = s ^ (s << 13);
   s = s ^ (s >> 17);
   s = s ^ (s << 5);
   return s;
endfunction

`endif

/* testbench/tbDesKeySchedule.sv */
`timescale 1ns/1ps

module tbDesKeySchedule import desKeyPkg::*; ();

   `include "tbDesRefModel.svh"

   localparam int REQ_TOTAL      = 1 + 1 + 8 + 1 + IN_CREDITS;
   localparam int TIMEOUT_CYCLES = 40 * REQ_TOTAL + 200;

   logic        clk = 1'b0;
   logic        arstN;
   logic        reqValid;
   keyReq_t     req;
   logic        reqCredit;
   logic        subkeyCredit;
   logic        subkeyValid;
   subkey_t     subkey;

   subkey_t     rxWords [256];
   int          recvCnt = 0;
   int          creditPulses = 0;
   int          granted = 0;
   int          creditTarget = 0;
   int          sentCnt = 0;
   int          expTotal = 0;
   int          cycleCnt = 0;
   int          errCnt = 0;
   int          testsRun = 0;
   int          testsFailed = 0;
   logic [31:0] rngState = 32'd66387;

   always #20 clk = ~clk;

   desKeySchedule desKeySchedule_i (
      .clk(clk), .arstN(arstN), .reqValid(reqValid), .req(req), .reqCredit(reqCredit),
      .subkeyCredit(subkeyCredit), .subkeyValid(subkeyValid), .subkey(subkey)
   );

   // ****************************************
   // monitor and downstream credits
   // ****************************************

   // credits go out only up to the subkeys the running test expects.
   always @(posedge clk) begin
      cycleCnt <= cycleCnt + 1;
      if (subkeyValid) begin
         rxWords[recvCnt] <= subkey;
         recvCnt          <= recvCnt + 1;
      end
      if (reqCredit) begin
         creditPulses <= creditPulses + 1;
      end
      if (arstN && granted < creditTarget && granted - recvCnt < OUT_CREDIT_MAX) begin
         subkeyCredit <= 1'b1;
         granted      <= granted + 1;
      end else begin
         subkeyCredit <= 1'b0;
      end
   end

   // ****************************************
   // helpers
   // ****************************************

   function automatic logic [63:0] randomKey();
      logic [31:0] hi;
      hi       = xorshift32(rngState);
      rngState = xorshift32(hi);
      return {hi, rngState};
   endfunction

   // reqValid stays high across back to back sends while upstream holds credits.
   task automatic sendReq(input logic [63:0] k64, input logic [3:0] tag, input keyOp_t opSel);
      while (sentCnt - creditPulses >= IN_CREDITS) begin
         @(posedge clk);
         reqValid <= 1'b0;
      end
      @(posedge clk);
      reqValid <= 1'b1;
      req      <= '{keyTag: tag, op: opSel, key: stripParity(k64)};
      sentCnt  = sentCnt + 1;
   endtask

   task automatic endReq();
      @(posedge clk);
      reqValid <= 1'b0;
   endtask

   task automatic waitWords(input int total);
      while (recvCnt < total) begin
         @(posedge clk);
      end
   endtask

   // fields print as tag/round/last/value.
   function automatic int checkReq(input string name, input logic [63:0] k64,
                                   input logic [3:0] tag, input keyOp_t opSel, input int base);
      logic [767:0] ks;
      subkey_t      want;
      subkey_t      got;
      int           errs;
      ks   = refSchedule(k64);
      errs = 0;
      for (int i = 0; i < 16; i++) begin
         want.keyTag = tag;
         want.round  = (opSel == OP_ENCRYPT) ? 4'(i) : 4'(15 - i);
         want.last   = (i == 15);
         want.value  = ks[48*want.round +: 48];
         got         = rxWords[base + i];
         if (got != want) begin
            $display("ERR %s word %0d: expected %h/%0d/%b/%h actual %h/%0d/%b/%h", name, i,
                     want.keyTag, want.round, want.last, want.value,
                     got.keyTag, got.round, got.last, got.value);
            errs++;
         end
      end
      return errs;
   endfunction

   task automatic reportTest(input string name, input int errs);
      testsRun++;
      errCnt = errCnt + errs;
      if (errs == 0) begin
         $display("test %s: ok", name);
      end else begin
         testsFailed++;
         $display("test %s: %0d errors", name, errs);
      end
   endtask

   task automatic runSingleKey(input string name, input logic [63:0] k64, input logic [3:0] tag,
                               input keyOp_t opSel, output int base, output int errs);
      base         = expTotal;
      expTotal     = expTotal + 16;
      creditTarget <= expTotal;
      sendReq(k64, tag, opSel);
      endReq();
      waitWords(expTotal);
      errs = checkReq(name, k64, tag, opSel, base);
   endtask

   // ****************************************
   // tests
   // ****************************************

   task automatic knownVector();
      int base;
      int errs;
      runSingleKey("knownVector", 64'h133457799BBCDFF1, 4'h1, OP_ENCRYPT, base, errs);
      if (rxWords[base].value != 48'h1B02EFFC7072) begin
         $display("ERR knownVector K1: expected 1b02effc7072 actual %h",
                  rxWords[base].value);
         errs++;
      end
      if (rxWords[base + 15].value != 48'hCB3D8B0E17F5) begin
         $display("ERR knownVector K16: expected cb3d8b0e17f5 actual %h",
                  rxWords[base + 15].value);
         errs++;
      end
      reportTest("knownVector", errs);
   endtask

   // the model's encrypt subkeys are expected in reverse, rounds 15 down to 0.
   task automatic decryptOrder();
      int base;
      int errs;
      runSingleKey("decryptOrder", 64'h133457799BBCDFF1, 4'h2, OP_DECRYPT, base, errs);
      reportTest("decryptOrder", errs);
   endtask

   task automatic randomKeys();
      logic [63:0] keys [8];
      int          base;
      int          errs;
      base         = expTotal;
      expTotal     = expTotal + 8 * 16;
      creditTarget <= expTotal;
      for (int i = 0; i < 8; i++) begin
         keys[i] = randomKey();
         sendReq(keys[i], keys[i][7:4], keyOp_t'(keys[i][15]));
      end
      endReq();
      waitWords(expTotal);
      errs = 0;
      for (int i = 0; i < 8; i++) begin
         errs += checkReq("randomKeys", keys[i], keys[i][7:4], keyOp_t'(keys[i][15]),
                          base + 16 * i);
      end
      reportTest("randomKeys", errs);
   endtask

   // with no credits the subkey buffer fills and the engine stalls.
   task automatic starvation();
      logic [63:0] k64;
      int          base;
      int          errs;
      k64  = randomKey();
      base = expTotal;
      errs = 0;
      sendReq(k64, 4'h9, OP_ENCRYPT);
      endReq();
      repeat (30) begin
         @(posedge clk);
         if (subkeyValid) begin
            $display("starvation: a subkey was sent without any credit");
            errs++;
         end
      end
      for (int n = 1; n <= 16; n++) begin
         expTotal     = base + n;
         creditTarget <= expTotal;
         waitWords(expTotal);
         repeat (3) @(posedge clk);
         if (recvCnt != expTotal) begin
            $display("ERR starvation subkey count: expected %0d actual %0d", expTotal, recvCnt);
            errs++;
         end
      end
      errs += checkReq("starvation", k64, 4'h9, OP_ENCRYPT, base);
      reportTest("starvation", errs);
   endtask

   task automatic requestCredits();
      logic [63:0] keys [IN_CREDITS];
      int          base;
      int          pulses0;
      int          errs;
      errs = 0;
      if (sentCnt != creditPulses) begin
         $display("requestCredits: earlier requests still hold upstream credits");
         errs++;
      end
      base         = expTotal;
      pulses0      = creditPulses;
      expTotal     = expTotal + 16 * IN_CREDITS;
      creditTarget <= expTotal;
      for (int i = 0; i < IN_CREDITS; i++) begin
         keys[i] = randomKey();
         sendReq(keys[i], 4'(10 + i), keyOp_t'(i % 2));
      end
      endReq();
      waitWords(expTotal);
      for (int i = 0; i < IN_CREDITS; i++) begin
         errs += checkReq("requestCredits", keys[i], 4'(10 + i), keyOp_t'(i % 2), base + 16 * i);
      end
      if (creditPulses - pulses0 != IN_CREDITS) begin
         $display("ERR requestCredits pulses: expected %0d actual %0d", IN_CREDITS,
                  creditPulses - pulses0);
         errs++;
      end
      reportTest("requestCredits", errs);
   endtask

   initial begin
      arstN        = 1'b0;
      reqValid     = 1'b0;
      req          = '0;
      subkeyCredit = 1'b0;
      repeat (2) @(posedge clk);
      arstN <= 1'b1;
      @(posedge clk);
      knownVector();
      decryptOrder();
      randomKeys();
      starvation();
      requestCredits();
      $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errCnt);
      if (errCnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      while (cycleCnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
      end
      $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
   end

endmodule

/* verilog/desKeySchedule.sv */
`timescale 1ns/1ps

module desKeySchedule import desKeyPkg::*; (
   input  logic    clk,
   input  logic    arstN,
   input  logic    reqValid,
   input  keyReq_t req,
   output logic    reqCredit,
   input  logic    subkeyCredit,
   output logic    subkeyValid,
   output subkey_t subkey
);

   logic        headValid;
   keyReq_t     headReq;
   logic        headTake;
   logic [55:0] cdLoad;
   logic [55:0] cdRound;
   logic [47:0] subkeyValue;
   logic        stepValid;
   subkey_t     stepWord;
   logic        outRoom;

   // ****************************************
   // request side and PC-1
   // ****************************************

   keyIntake keyIntake_i (
      .clk(clk), .arstN(arstN), .reqValid(reqValid), .req(req), .reqCredit(reqCredit),
      .headValid(headValid), .headReq(headReq), .headTake(headTake)
   );

   keyPermChoice1 keyPermChoice1_i (.key(headReq.key), .cd(cdLoad));

   // ****************************************
   // rounds, PC-2 and subkey side
   // ****************************************

   roundKeyEngine roundKeyEngine_i (
      .clk(clk), .arstN(arstN), .headValid(headValid), .headReq(headReq),
      .cdLoad(cdLoad), .headTake(headTake), .cdRound(cdRound), .subkeyValue(subkeyValue),
      .stepValid(stepValid), .stepWord(stepWord), .outRoom(outRoom)
   );

   keyPermChoice2 keyPermChoice2_i (.cd(cdRound), .subkeyValue(subkeyValue));

   subkeyOutput subkeyOutput_i (
      .clk(clk), .arstN(arstN), .stepValid(stepValid), .stepWord(stepWord),
      .outRoom(outRoom), .subkeyCredit(subkeyCredit), .subkeyValid(subkeyValid),
      .subkey(subkey)
   );

endmodule

/* verilog/subkeyOutput.sv */
`timescale 1ns/1ps

module subkeyOutput import desKeyPkg::*; (
   input  logic    clk,
   input  logic    arstN,
   input  logic    stepValid,
   input  subkey_t stepWord,
   output logic    outRoom,
   input  logic    subkeyCredit,
   output logic    subkeyValid,
   output subkey_t subkey
);

   subkey_t                                 entry [OUT_DEPTH];
   logic [$clog2(OUT_DEPTH)-1:0]            wrPtr;
   logic [$clog2(OUT_DEPTH)-1:0]            rdPtr;
   logic [$clog2(OUT_DEPTH+1)-1:0]          count;
   logic [$clog2(OUT_CREDIT_MAX+1)-1:0]     creditCnt;
   logic                                    push;
   logic                                    send;

   assign outRoom = (count < OUT_DEPTH);
   assign push    = stepValid && outRoom;

   // a credit arriving in this cycle already allows a send.
   assign send = (count != '0) && ((creditCnt != '0) || subkeyCredit);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         wrPtr       <= '0;
         rdPtr       <= '0;
         count       <= '0;
         creditCnt   <= '0;
         subkeyValid <= 1'b0;
      end else begin
         if (push) begin
            wrPtr <= wrPtr + 1'b1;
         end
         if (send) begin
            rdPtr <= rdPtr + 1'b1;
         end
         count       <= count + push - send;
         creditCnt   <= creditCnt + subkeyCredit - send;
         subkeyValid <= send;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         entry[wrPtr] <= stepWord;
      end
      if (send) begin
         subkey <= entry[rdPtr];
      end
   end

   aCreditMax: assert property (@(posedge clk) disable iff (!arstN)
      (subkeyCredit && !send) |-> (creditCnt < OUT_CREDIT_MAX));

endmodule

/* verilog/roundKeyEngine.sv */
`timescale 1ns/1ps

module roundKeyEngine import desKeyPkg::*; (
   input  logic        clk,
   input  logic        arstN,
   input  logic        headValid,
   input  keyReq_t     headReq,
   input  logic [55:0] cdLoad,
   output logic        headTake,
   output logic [55:0] cdRound,
   input  logic [47:0] subkeyValue,
   output logic        stepValid,
   output subkey_t     stepWord,
   input  logic        outRoom
);

   engState_t   state;
   logic [55:0] cdReg;
   logic [55:0] cdStart;
   logic [3:0]  roundCnt;
   logic [3:0]  nextIdx;
   logic [3:0]  tagReg;
   keyOp_t      opReg;
   logic        doRot;
   logic        shiftTwo;
   logic        isLast;

   function automatic logic [27:0] rot28(input logic [27:0] h, input logic left,
                                         input logic two);
      if (left) begin
         return two ? {h[25:0], h[27:26]} : {h[26:0], h[27]};
      end
      return two ? {h[1:0], h[27:2]} : {h[0], h[27:1]};
   endfunction

   // ****************************************
   // rotation choice
   // ****************************************

   // decrypt starts from CD16, which equals the loaded CD0, then undoes rounds 16 to 2.
   always_comb begin
      nextIdx  = roundCnt + 4'd1;
      doRot    = 1'b1;
      shiftTwo = !SHIFT_ONE[roundCnt];
      if (opReg == OP_DECRYPT) begin
         doRot    = (roundCnt != 4'(ROUND_COUNT - 1));
         shiftTwo = !SHIFT_ONE[nextIdx];
      end
   end

   assign cdRound = doRot ? {rot28(cdReg[55:28], opReg == OP_ENCRYPT, shiftTwo),
                             rot28(cdReg[27:0], opReg == OP_ENCRYPT, shiftTwo)}
                          : cdReg;

   assign isLast    = (opReg == OP_ENCRYPT) ? (roundCnt == 4'(ROUND_COUNT - 1))
                                            : (roundCnt == 4'd0);
   assign headTake  = (state == ENG_IDLE) && headValid;
   assign stepValid = (state == ENG_RUN) && outRoom;
   assign stepWord  = '{keyTag: tagReg, round: roundCnt, last: isLast, value: subkeyValue};

   // ****************************************
   // state
   // ****************************************

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state    <= ENG_IDLE;
         roundCnt <= '0;
      end else begin
         case (state)
            ENG_IDLE: begin
               if (headValid) begin
                  state    <= ENG_RUN;
                  roundCnt <= (headReq.op == OP_DECRYPT) ? 4'(ROUND_COUNT - 1) : 4'd0;
               end
            end
            ENG_RUN: begin
               if (outRoom) begin
                  if (isLast) begin
                     state <= ENG_IDLE;
                  end else if (opReg == OP_ENCRYPT) begin
                     roundCnt <= roundCnt + 4'd1;
                  end else begin
                     roundCnt <= roundCnt - 4'd1;
                  end
               end
            end
            default: state <= ENG_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (headTake) begin
         cdReg   <= cdLoad;
         cdStart <= cdLoad;
         tagReg  <= headReq.keyTag;
         opReg   <= headReq.op;
      end else if (stepValid) begin
         cdReg <= cdRound;
      end
   end

   // the sixteen rotations add up to 28 places, so encrypt ends on the loaded halves
   // and decrypt ends on CD1, one place left of them.
   aRotTotal: assert property (@(posedge clk) disable iff (!arstN)
      (stepValid && isLast) |-> (cdRound == ((opReg == OP_ENCRYPT) ? cdStart :
         {rot28(cdStart[55:28], 1'b1, 1'b0), rot28(cdStart[27:0], 1'b1, 1'b0)})));

endmodule

/* verilog/keyPermChoice2.sv */
`timescale 1ns/1ps

module keyPermChoice2 (
   input  logic [55:0] cd,
   output logic [47:0] subkeyValue
);

   // cd[55] is C bit 1 and cd[0] is D bit 28.
   // PC-2 leaves out positions 9, 18, 22, 25, 35, 38, 43 and 54.

   // ****************************************
   // bits from C
   // ****************************************

   assign subkeyValue[47:24] = {
      cd[42], cd[39], cd[45], cd[32], cd[55], cd[51],
      cd[53], cd[28], cd[41], cd[50], cd[35], cd[46],
      cd[33], cd[37], cd[44], cd[52], cd[30], cd[48],
      cd[40], cd[49], cd[29], cd[36], cd[43], cd[54]
   };

   // ****************************************
   // bits from D
   // ****************************************

   assign subkeyValue[23:0] = {
      cd[15], cd[4],  cd[25], cd[19], cd[9],  cd[1],
      cd[26], cd[16], cd[5],  cd[11], cd[23], cd[8],
      cd[12], cd[7],  cd[17], cd[0],  cd[22], cd[3],
      cd[10], cd[14], cd[6],  cd[20], cd[27], cd[24]
   };

endmodule

/* verilog/keyPermChoice1.sv */
`timescale 1ns/1ps

module keyPermChoice1 (
   input  logic [55:0] key,
   output logic [55:0] cd
);

   // full[63] is bit 1 of the 64-bit key, full[0] is bit 64.
   logic [63:0] full;

   // ****************************************
   // byte rebuild with parity
   // ****************************************

   // each byte is its seven key bits followed by their XOR as the low bit.
   for (genvar b = 0; b < 8; b++) begin : gByte
      assign full[8*b+7:8*b+1] = key[7*b+6:7*b];
      assign full[8*b]         = ^key[7*b+6:7*b];
   end

   // ****************************************
   // PC-1 selection
   // ****************************************

   // the parity positions (multiples of eight) are never picked.
   assign cd[55:28] = {
      full[7],  full[15], full[23], full[31], full[39], full[47], full[55],
      full[63], full[6],  full[14], full[22], full[30], full[38], full[46],
      full[54], full[62], full[5],  full[13], full[21], full[29], full[37],
      full[45], full[53], full[61], full[4],  full[12], full[20], full[28]
   };

   assign cd[27:0] = {
      full[1],  full[9],  full[17], full[25], full[33], full[41], full[49],
      full[57], full[2],  full[10], full[18], full[26], full[34], full[42],
      full[50], full[58], full[3],  full[11], full[19], full[27], full[35],
      full[43], full[51], full[59], full[36], full[44], full[52], full[60]
   };

endmodule

/* verilog/keyIntake.sv */
`timescale 1ns/1ps

module keyIntake import desKeyPkg::*; (
   input  logic    clk,
   input  logic    arstN,
   input  logic    reqValid,
   input  keyReq_t req,
   output logic    reqCredit,
   output logic    headValid,
   output keyReq_t headReq,
   input  logic    headTake
);

   keyReq_t                              slot [IN_CREDITS];
   logic [$clog2(IN_CREDITS)-1:0]        wrPtr;
   logic [$clog2(IN_CREDITS)-1:0]        rdPtr;
   logic [$clog2(IN_CREDITS+1)-1:0]      count;
   logic                                 deq;

   assign headValid = (count != '0);
   assign headReq   = slot[rdPtr];
   assign deq       = headTake && headValid;

   // each freed slot goes straight back to upstream as a credit.
   assign reqCredit = deq;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (reqValid) begin
            wrPtr <= wrPtr + 1'b1;
         end
         if (deq) begin
            rdPtr <= rdPtr + 1'b1;
         end
         count <= count + reqValid - deq;
      end
   end

   always_ff @(posedge clk) begin
      if (reqValid) begin
         slot[wrPtr] <= req;
      end
   end

   // upstream only sends against a credit, so a full buffer never sees a request.
   aReqNotFull: assert property (@(posedge clk) disable iff (!arstN)
      reqValid |-> (count != IN_CREDITS));

endmodule

/* verilog/desKeyPkg.sv */
package desKeyPkg;

   // ****************************************
   // sizes and credit depths
   // ****************************************

   localparam int IN_CREDITS     = 2;
   localparam int OUT_DEPTH      = 2;
   localparam int OUT_CREDIT_MAX = 7;
   localparam int ROUND_COUNT    = 16;

   // bit r is set where round r+1 rotates by one place (rounds 1, 2, 9 and 16).
   localparam logic [15:0] SHIFT_ONE = 16'b1000_0001_0000_0011;

   // ****************************************
   // types
   // ****************************************

   typedef enum logic {
      OP_ENCRYPT,
      OP_DECRYPT
   } keyOp_t;

   typedef enum logic {
      ENG_IDLE,
      ENG_RUN
   } engState_t;

   // key[55] is key bit 1, the first bit of the first key byte.
   typedef struct packed {
      logic [3:0]  keyTag;
      keyOp_t      op;
      logic [55:0] key;
   } keyReq_t;

   typedef struct packed {
      logic [3:0]  keyTag;
      logic [3:0]  round;
      logic        last;
      logic [47:0] value;
   } subkey_t;

endpackage
